//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rpSdMapperTb
FILELIST  = sim.f
OBJDIR    = obj_dir
SIMBIN    = $(OBJDIR)/V$(TOP)
LOGFILE   = sim.log
SOURCES   = $(wildcard hdl/*.sv) $(wildcard bench/*.sv)
VECTORS   = bench/rpSdVectors.txt

.PHONY: all run clean

all: $(SIMBIN)

$(SIMBIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIMBIN) $(VECTORS)
	./$(SIMBIN) > $(LOGFILE) 2>&1 || true
	@cat $(LOGFILE)
	@if grep -q '>>> FAIL' $(LOGFILE); then \
		echo "simulation failed, see $(LOGFILE)"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOGFILE); then \
		echo "simulation ended without a result, see $(LOGFILE)"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOGFILE)

//--- bench/rpSdMapperTb.sv
`timescale 1ns/1ps

module rpSdMapperTb
   import rpSdPkg::*;
();

   localparam int UNIT_SPAN_LOG2 = 21;
   localparam int MAX_VECTORS    = 64;
   localparam int VEC_WORDS      = 7;
   localparam int TIMEOUT_CYCLES = 200;

   logic    clk;
   logic    rst;
   logic    reqValid;
   chsReq_t req;
   logic    busy;
   logic    rspValid;
   sdRsp_t  rsp;

   // Seven words per vector in file column order
   logic [31:0] vecMem [0:MAX_VECTORS*VEC_WORDS-1];
   integer      seed;
   int          numVectors;

   rpSdMapper #(
      .UNIT_SPAN_LOG2 (UNIT_SPAN_LOG2)
   ) i_rpSdMapper
   (
      .clk      (clk),
      .rst      (rst),
      .reqValid (reqValid),
      .req      (req),
      .busy     (busy),
      .rspValid (rspValid),
      .rsp      (rsp)
   );

   // 4 ns clock
   initial clk = 1'b0;
   always #2 clk = ~clk;

   //////////////////////////////////////////////////
   // Checks and failure
   //////////////////////////////////////////////////

   task automatic abortRun();
      $display(">>> FAIL");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic checkFault(input string name, input chsFault_t got, input chsFault_t exp);
      if (got !== exp)
      begin
         $display("error at time %0t: %s got %b expected %b", $time, name, got, exp);
         abortRun();
      end
   endtask

   task automatic checkAddr(input string name, input sdAddr_t got, input sdAddr_t exp);
      if (got !== exp)
      begin
         $display("error at time %0t: %s got %h expected %h", $time, name, got, exp);
         abortRun();
      end
   endtask

   // Control level compare for busy and rspValid
   task automatic checkLevel(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("error at time %0t: %s got %b expected %b", $time, name, got, exp);
         abortRun();
      end
   endtask

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   task automatic loadVectors();
      int   vi;
      logic found;
      $readmemh("bench/rpSdVectors.txt", vecMem);
      numVectors = 0;
      found = 1'b0;
      // Unit column of 8 or more marks the end
      for (vi = 0; vi < MAX_VECTORS && !found; vi++)
      begin
         if ($isunknown(vecMem[vi*VEC_WORDS]))
         begin
            $display("vector file is missing or ends without an end marker");
            abortRun();
         end
         else if (vecMem[vi*VEC_WORDS] >= 32'd8)
            found = 1'b1;
         else
            numVectors++;
      end
      if (!found)
      begin
         $display("no end marker found in the vector file");
         abortRun();
      end
   endtask

   // Random garbage on req that the DUT must ignore
   task automatic driveReqNoise();
      logic [31:0] rnd;
      rnd = $random(seed);
      req.unit   = rnd[2:0];
      req.drive  = driveType_t'(rnd[3]);
      req.cyl    = rnd[13:4];
      req.track  = rnd[19:14];
      req.sector = rnd[25:20];
   endtask

   task automatic waitIdle();
      int cycles;
      cycles = 0;
      while (busy !== 1'b0)
      begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT_CYCLES)
         begin
            $display("timeout: busy stayed high before the next request");
            abortRun();
         end
      end
   endtask

   // One-cycle strobe with the vector's request
   task automatic sendRequest(input int base);
      req.unit   = vecMem[base][2:0];
      req.drive  = driveType_t'(vecMem[base+1][0]);
      req.cyl    = vecMem[base+2][9:0];
      req.track  = vecMem[base+3][5:0];
      req.sector = vecMem[base+4][5:0];
      reqValid   = 1'b1;
      @(negedge clk);
      reqValid = 1'b0;
      checkLevel("busy", busy, 1'b1);
   endtask

   // Busy must hold until the single response
   task automatic waitResponse();
      int cycles;
      cycles = 0;
      while (rspValid !== 1'b1)
      begin
         checkLevel("busy", busy, 1'b1);
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT_CYCLES)
         begin
            $display("timeout: no response strobe after the request");
            abortRun();
         end
         // Merge stage has taken the unit by now
         driveReqNoise();
      end
      checkLevel("busy", busy, 1'b1);
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial
   begin
      int        vi;
      int        base;
      chsFault_t expFault;
      sdAddr_t   expAddr;
      rst      = 1'b1;
      reqValid = 1'b0;
      req      = '0;
      seed     = 32'h97ff5e34;
      loadVectors();
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      // Quiet outputs before the first request
      repeat (6)
      begin
         @(negedge clk);
         checkLevel("busy", busy, 1'b0);
         checkLevel("rspValid", rspValid, 1'b0);
         driveReqNoise();
      end
      for (vi = 0; vi < numVectors; vi++)
      begin
         base     = vi * VEC_WORDS;
         expFault = vecMem[base+5][2:0];
         expAddr  = vecMem[base+6];
         waitIdle();
         sendRequest(base);
         waitResponse();
         checkFault("rsp.fault", rsp.fault, expFault);
         // Block address only defined for in-range requests
         if (expFault == '0)
            checkAddr("rsp.addr", rsp.addr, expAddr);
         @(negedge clk);
         checkLevel("rspValid", rspValid, 1'b0);
         checkLevel("busy", busy, 1'b0);
         driveReqNoise();
      end
      if (numVectors > 0)
      begin
         $display(">>> PASS");
         $finish;
      end
      else
      begin
         $display("vector file holds no requests");
         abortRun();
      end
   end

endmodule

//--- bench/rpSdVectors.txt
// Columns in hex: unit drive cyl track sector fault addr
// Drive 0 is RP06, 1 is RP07; fault bits are cyl trk sec; unit 8 ends the list
// Zero and single steps on RP06
0 0 000 00 00 0 00000000
0 0 001 00 00 0 000002f8
0 0 000 01 00 0 00000028
0 0 000 00 01 0 00000002
// Last sector of each drive type
0 0 32e 12 13 0 00097386
0 1 275 1f 2a 0 001a747e
// Same CHS on both drive types
0 0 064 05 07 0 000129b6
0 1 064 05 07 0 000434bc
// Unit partition bases
1 0 064 05 07 0 002129b6
3 0 064 05 07 0 006129b6
7 0 064 05 07 0 00e129b6
5 1 275 1f 2a 0 00ba747e
2 1 000 19 1e 0 004008a2
// Single faults
0 0 32f 00 00 4 00000000
0 0 000 13 00 2 00000000
0 0 000 00 14 1 00000000
0 1 276 00 00 4 00000000
0 1 000 20 00 2 00000000
0 1 000 00 2b 1 00000000
0 0 32e 12 14 1 00000000
0 1 000 1f 32 1 00000000
// Combined faults
0 0 3ff 3f 3f 7 00000000
0 1 2bc 28 00 6 00000000
0 0 000 19 1e 3 00000000
// Good requests after faults
4 0 002 03 04 0 00800670
6 1 001 01 01 0 00c00b18
// End of list
8 0 000 00 00 0 00000000

//--- hdl/chsCheck.sv
`timescale 1ns/1ps

module chsCheck
   import rpSdPkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      reqValid,
   input  chsReq_t   req,
   output logic      faultValid,
   output chsFault_t fault
);

   chsFault_t faultNext;

   //////////////////////////////////////////////////
   // Range compare
   //////////////////////////////////////////////////

   // Each field must be below the count for its drive type
   always_comb
   begin
      faultNext.cylErr = (req.cyl    >= numCyls(req.drive));
      faultNext.trkErr = (req.track  >= numTracks(req.drive));
      faultNext.secErr = (req.sector >= numSectors(req.drive));
   end

   //////////////////////////////////////////////////
   // Result register
   //////////////////////////////////////////////////

   // Strobe follows the request by one cycle
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         faultValid <= 1'b0;
      end
      else
      begin
         faultValid <= reqValid;
      end
   end

   // Flags captured with the request
   always_ff @(posedge clk)
   begin
      if (reqValid)
      begin
         fault <= faultNext;
      end
   end

   // No strobe without a request one cycle earlier
   assertFaultTiming: assert property (@(posedge clk) disable iff (rst)
      faultValid |-> $past(reqValid));

endmodule

//--- hdl/rpSdMapper.sv
`timescale 1ns/1ps

module rpSdMapper
   import rpSdPkg::*;
#(
   parameter int unsigned UNIT_SPAN_LOG2 = 21
)
(
   input  logic    clk,
   input  logic    rst,
   input  logic    reqValid,
   input  chsReq_t req,
   output logic    busy,
   output logic    rspValid,
   output sdRsp_t  rsp
);

   logic      faultValid;
   chsFault_t fault;
   logic      calcDone;
   sdAddr_t   calcSum;
   logic      calcBusy;

   //////////////////////////////////////////////////
   // Parallel checker and calculator
   //////////////////////////////////////////////////

   // Range check, one cycle
   chsCheck i_chsCheck
   (
      .clk        (clk),
      .rst        (rst),
      .reqValid   (reqValid),
      .req        (req),
      .faultValid (faultValid),
      .fault      (fault)
   );

   // Linear sector, drive-dependent latency
   sdSectorCalc i_sdSectorCalc
   (
      .clk      (clk),
      .rst      (rst),
      .start    (reqValid),
      .req      (req),
      .calcDone (calcDone),
      .calcSum  (calcSum),
      .calcBusy (calcBusy)
   );

   //////////////////////////////////////////////////
   // Merge and response
   //////////////////////////////////////////////////

   sdReqMerge #(
      .UNIT_SPAN_LOG2 (UNIT_SPAN_LOG2)
   ) i_sdReqMerge
   (
      .clk        (clk),
      .rst        (rst),
      .faultValid (faultValid),
      .fault      (fault),
      .unit       (req.unit),
      .calcDone   (calcDone),
      .calcSum    (calcSum),
      .calcBusy   (calcBusy),
      .busy       (busy),
      .rspValid   (rspValid),
      .rsp        (rsp)
   );

endmodule

//--- hdl/rpSdPkg.sv
package rpSdPkg;

   //////////////////////////////////////////////////
   // Drive types and geometry
   //////////////////////////////////////////////////

   // Emulated drive families
   typedef enum logic
   {
      RP06 = 1'b0,
      RP07 = 1'b1
   } driveType_t;

   // RP06 geometry
   localparam logic [9:0] RP06_NUM_CYL = 10'd815;
   localparam logic [5:0] RP06_NUM_TRK = 6'd19;
   localparam logic [5:0] RP06_NUM_SEC = 6'd20;

   // RP07 geometry
   localparam logic [9:0] RP07_NUM_CYL = 10'd630;
   localparam logic [5:0] RP07_NUM_TRK = 6'd32;
   localparam logic [5:0] RP07_NUM_SEC = 6'd43;

   // Geometry lookup by drive type
   function automatic logic [9:0] numCyls(input driveType_t drive);
      return (drive == RP07) ? RP07_NUM_CYL : RP06_NUM_CYL;
   endfunction

   function automatic logic [5:0] numTracks(input driveType_t drive);
      return (drive == RP07) ? RP07_NUM_TRK : RP06_NUM_TRK;
   endfunction

   function automatic logic [5:0] numSectors(input driveType_t drive);
      return (drive == RP07) ? RP07_NUM_SEC : RP06_NUM_SEC;
   endfunction

   //////////////////////////////////////////////////
   // Request and response words
   //////////////////////////////////////////////////

   // Disk address request, 26 bits
   typedef struct packed
   {
      logic [2:0] unit;
      driveType_t drive;
      logic [9:0] cyl;
      logic [5:0] track;
      logic [5:0] sector;
   } chsReq_t;

   // One flag per out-of-range field
   typedef struct packed
   {
      logic cylErr;
      logic trkErr;
      logic secErr;
   } chsFault_t;

   // SD block address
   typedef logic [31:0] sdAddr_t;

   // Response, 35 bits
   typedef struct packed
   {
      sdAddr_t   addr;
      chsFault_t fault;
   } sdRsp_t;

endpackage

//--- hdl/sdReqMerge.sv
`timescale 1ns/1ps

module sdReqMerge
   import rpSdPkg::*;
#(
   parameter int unsigned UNIT_SPAN_LOG2 = 21
)
(
   input  logic      clk,
   input  logic      rst,
   input  logic      faultValid,
   input  chsFault_t fault,
   input  logic [2:0] unit,
   input  logic      calcDone,
   input  sdAddr_t   calcSum,
   input  logic      calcBusy,
   output logic      busy,
   output logic      rspValid,
   output sdRsp_t    rsp
);

   logic      holdValid;
   chsFault_t faultHold;
   logic [2:0] unitHold;
   sdAddr_t   unitBase;
   logic      anyFault;

   //////////////////////////////////////////////////
   // Pending request tracking
   //////////////////////////////////////////////////

   // Checker result waits here for the slower calculator
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         holdValid <= 1'b0;
         rspValid  <= 1'b0;
      end
      else
      begin
         if (faultValid)
            holdValid <= 1'b1;
         else if (calcDone)
            holdValid <= 1'b0;
         rspValid <= calcDone;
      end
   end

   always_ff @(posedge clk)
   begin
      if (faultValid)
      begin
         faultHold <= fault;
         unitHold  <= unit;
      end
   end

   //////////////////////////////////////////////////
   // Response forming
   //////////////////////////////////////////////////

   // Each unit owns a power-of-two partition on the card
   assign unitBase = sdAddr_t'(unitHold) << UNIT_SPAN_LOG2;
   assign anyFault = |faultHold;

   // Faulted requests report the raw sum, no partition offset
   always_ff @(posedge clk)
   begin
      if (calcDone)
      begin
         rsp.fault <= faultHold;
         rsp.addr  <= anyFault ? calcSum : calcSum + unitBase;
      end
   end

   // Covers calculation, wait for merge, and response cycle
   assign busy = calcBusy | holdValid | rspValid;

   // Calculator finishes only after the checker result is held
   assertHeldFault: assert property (@(posedge clk) disable iff (rst)
      calcDone |-> holdValid);

endmodule

//--- hdl/sdSectorCalc.sv
`timescale 1ns/1ps

module sdSectorCalc
   import rpSdPkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  logic    start,
   input  chsReq_t req,
   output logic    calcDone,
   output sdAddr_t calcSum,
   output logic    calcBusy
);

   // Calculator phases
   typedef enum logic [1:0]
   {
      sIdle,
      sTrack,
      sSector,
      sDouble
   } calcState_t;

   calcState_t state;
   logic [5:0] loop;
   chsReq_t    reqHold;
   sdAddr_t    sum;
   sdAddr_t    temp;

   //////////////////////////////////////////////////
   // Control FSM
   //////////////////////////////////////////////////

   // Loop counter runs from the geometry count down to zero
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state    <= sIdle;
         loop     <= '0;
         calcDone <= 1'b0;
      end
      else
      begin
         calcDone <= 1'b0;
         case (state)
            sIdle:
            begin
               // Geometry from the live request, it is latched this edge
               if (start)
               begin
                  loop  <= numTracks(req.drive);
                  state <= sTrack;
               end
            end
            sTrack:
            begin
               if (loop == '0)
               begin
                  loop  <= numSectors(reqHold.drive);
                  state <= sSector;
               end
               else
               begin
                  loop <= loop - 6'd1;
               end
            end
            sSector:
            begin
               if (loop == '0)
               begin
                  state <= sDouble;
               end
               else
               begin
                  loop <= loop - 6'd1;
               end
            end
            sDouble:
            begin
               // Result is final after this edge
               calcDone <= 1'b1;
               state    <= sIdle;
            end
            default:
            begin
               state <= sIdle;
            end
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Adder datapath
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      case (state)
         sIdle:
         begin
            if (start)
            begin
               reqHold <= req;
               sum     <= '0;
               temp    <= sdAddr_t'(req.cyl);
            end
         end
         sTrack:
         begin
            // cyl * numTracks + track becomes the next addend
            if (loop == '0)
            begin
               sum  <= '0;
               temp <= sum + sdAddr_t'(reqHold.track);
            end
            else
            begin
               sum <= sum + temp;
            end
         end
         sSector:
         begin
            if (loop == '0)
               sum <= sum + sdAddr_t'(reqHold.sector);
            else
               sum <= sum + temp;
         end
         sDouble:
         begin
            // Two SD blocks per emulated sector
            sum <= sum + sum;
         end
         default:
         begin
            sum <= sum;
         end
      endcase
   end

   assign calcSum  = sum;
   assign calcBusy = (state != sIdle);

   // Requests must wait for the previous calculation
   assertStartIdle: assert property (@(posedge clk) disable iff (rst)
      start |-> !calcBusy);

   // Done is a single-cycle strobe
   assertDonePulse: assert property (@(posedge clk) disable iff (rst)
      calcDone |=> !calcDone);

endmodule

//--- sim.f
hdl/rpSdPkg.sv
hdl/chsCheck.sv
hdl/sdSectorCalc.sv
hdl/sdReqMerge.sv
hdl/rpSdMapper.sv
bench/rpSdMapperTb.sv
